// File: logic/dispatchCfgPkg.sv
`default_nettype none

package dispatchCfgPkg;

  // Lanes in one dispatch group.
  localparam int DispatchWidth = 4;

  // Branch checkpoints and the width of their ids.
  localparam int Checkpoints    = 8;
  localparam int CheckpointsLog = 3;

  // Register tag widths.
  localparam int PhysRegLog = 7;
  localparam int LogRegLog  = 5;

  // Instruction field widths.
  localparam int PcWidth     = 32;
  localparam int ImmWidth    = 16;
  localparam int OpcodeWidth = 8;

  // Occupancy counts carry one extra bit so a full structure can be reported.
  localparam int LsqSizeLog        = 4;
  localparam int IssueQSizeLog     = 5;
  localparam int ActiveListSizeLog = 6;

  typedef logic [Checkpoints-1:0]    checkpointMaskT;
  typedef logic [CheckpointsLog-1:0] checkpointIdT;
  typedef logic [PhysRegLog-1:0]     physRegT;
  typedef logic [LogRegLog-1:0]      logRegT;
  typedef logic [PcWidth-1:0]        pcT;
  typedef logic [ImmWidth-1:0]       immT;
  typedef logic [OpcodeWidth-1:0]    opcodeT;

  typedef logic [LsqSizeLog:0]        lsqCntT;
  typedef logic [IssueQSizeLog:0]     issueqCntT;
  typedef logic [ActiveListSizeLog:0] alCntT;

endpackage

`default_nettype wire

// File: logic/dispatchPacketPkg.sv
`default_nettype none

package dispatchPacketPkg;

  import dispatchCfgPkg::*;

  // One instruction as it leaves rename.
  typedef struct packed {
    pcT             pc;
    opcodeT         opcode;
    immT            immediate;
    logRegT         logDest;
    physRegT        phyDest;
    physRegT        phySrc1;
    physRegT        phySrc2;
    logic           isLoad;
    logic           isStore;
    logic           isBranch;
    checkpointIdT   checkpointId;
    checkpointMaskT branchMask;
  } renamedPktT;

  // Issue queue entry, everything needed to wake up and execute.
  typedef struct packed {
    opcodeT         opcode;
    immT            immediate;
    physRegT        phySrc1;
    physRegT        phySrc2;
    physRegT        phyDest;
    checkpointIdT   checkpointId;
    checkpointMaskT branchMask;
    logic           isLoad;
    logic           isStore;
  } issueqEntryT;

  // Active list entry, used at commit and on recovery.
  typedef struct packed {
    pcT      pc;
    logRegT  logDest;
    physRegT phyDest;
    logic    isLoad;
    logic    isStore;
    logic    isBranch;
  } alEntryT;

  // Load-store queue entry.
  typedef struct packed {
    checkpointMaskT branchMask;
    logic           isStore;
    logic           isLoad;
  } lsqEntryT;

  // Whole groups, lane 0 in the low slot.
  typedef renamedPktT     [DispatchWidth-1:0] renamedGroupT;
  typedef issueqEntryT    [DispatchWidth-1:0] issueqGroupT;
  typedef alEntryT        [DispatchWidth-1:0] alGroupT;
  typedef lsqEntryT       [DispatchWidth-1:0] lsqGroupT;
  typedef checkpointMaskT [DispatchWidth-1:0] maskGroupT;

endpackage

`default_nettype wire

// File: logic/dispatchCapacityCheck.sv
`timescale 1ns/1ps
`default_nettype none

module dispatchCapacityCheck
  import dispatchCfgPkg::*;
  import dispatchPacketPkg::*;
#(
  parameter int LsqSize        = 16,
  parameter int IssueQSize     = 32,
  parameter int ActiveListSize = 64
)
(
  input  renamedGroupT renamedGroup_i,
  input  lsqCntT       loadQueueCnt_i,
  input  lsqCntT       storeQueueCnt_i,
  input  issueqCntT    issueQueueCnt_i,
  input  alCntT        activeListCnt_i,
  output logic         spaceStall_o
);

  localparam int LaneCntW = $clog2(DispatchWidth) + 1;
  localparam int LsqNeedW = LsqSizeLog + 2;
  localparam int IqNeedW  = IssueQSizeLog + 2;
  localparam int AlNeedW  = ActiveListSizeLog + 2;

  logic [LaneCntW-1:0] loadCnt;
  logic [LaneCntW-1:0] storeCnt;
  logic [LsqNeedW-1:0] loadNeed;
  logic [LsqNeedW-1:0] storeNeed;
  logic [IqNeedW-1:0]  issueqNeed;
  logic [AlNeedW-1:0]  alNeed;
  logic                loadStall;
  logic                storeStall;
  logic                issueqStall;
  logic                alStall;

  // Loads and stores in this group.
  always_comb
  begin
    loadCnt  = '0;
    storeCnt = '0;
    for (int lane = 0; lane < DispatchWidth; lane++)
    begin
      loadCnt  = loadCnt + LaneCntW'(renamedGroup_i[lane].isLoad);
      storeCnt = storeCnt + LaneCntW'(renamedGroup_i[lane].isStore);
    end
  end

  // Sums are one bit wider than the counts so they never wrap.
  assign loadNeed   = LsqNeedW'(loadQueueCnt_i) + LsqNeedW'(loadCnt);
  assign storeNeed  = LsqNeedW'(storeQueueCnt_i) + LsqNeedW'(storeCnt);
  assign issueqNeed = IqNeedW'(issueQueueCnt_i) + IqNeedW'(DispatchWidth);
  assign alNeed     = AlNeedW'(activeListCnt_i) + AlNeedW'(DispatchWidth);

  assign loadStall   = (loadNeed > LsqSize);
  assign storeStall  = (storeNeed > LsqSize);
  assign issueqStall = (issueqNeed > IssueQSize);
  assign alStall     = (alNeed > ActiveListSize);

  // Any single full structure holds the group back.
  assign spaceStall_o = loadStall | storeStall | issueqStall | alStall;

  // The back end never reports more entries than a structure holds.
  always_comb
  begin
    assert final ($isunknown(loadQueueCnt_i) || loadQueueCnt_i <= LsqSize)
      else $error("load queue count %0d above capacity", loadQueueCnt_i);
    assert final ($isunknown(storeQueueCnt_i) || storeQueueCnt_i <= LsqSize)
      else $error("store queue count %0d above capacity", storeQueueCnt_i);
    assert final ($isunknown(issueQueueCnt_i) || issueQueueCnt_i <= IssueQSize)
      else $error("issue queue count %0d above capacity", issueQueueCnt_i);
    assert final ($isunknown(activeListCnt_i) || activeListCnt_i <= ActiveListSize)
      else $error("active list count %0d above capacity", activeListCnt_i);
  end

endmodule

`default_nettype wire

// File: logic/branchMaskUpdate.sv
`timescale 1ns/1ps
`default_nettype none

module branchMaskUpdate
  import dispatchCfgPkg::*;
  import dispatchPacketPkg::*;
(
  input  renamedGroupT renamedGroup_i,
  input  logic         ctrlVerified_i,
  input  checkpointIdT ctrlVerifiedId_i,
  output maskGroupT    updatedMask_o
);

  checkpointMaskT clearMask;

  // One-hot of the checkpoint that resolved correctly this cycle.
  always_comb
  begin
    clearMask = '0;
    if (ctrlVerified_i)
    begin
      clearMask[ctrlVerifiedId_i] = 1'b1;
    end
  end

  // Instructions no longer depend on a branch that is known good.
  always_comb
  begin
    for (int lane = 0; lane < DispatchWidth; lane++)
    begin
      updatedMask_o[lane] = renamedGroup_i[lane].branchMask & ~clearMask;
    end
  end

endmodule

`default_nettype wire

// File: logic/backEndPacketSplit.sv
`timescale 1ns/1ps
`default_nettype none

module backEndPacketSplit
  import dispatchCfgPkg::*;
  import dispatchPacketPkg::*;
(
  input  renamedGroupT renamedGroup_i,
  input  maskGroupT    updatedMask_i,
  output issueqGroupT  issueqGroup_o,
  output alGroupT      alGroup_o,
  output lsqGroupT     lsqGroup_o
);

  always_comb
  begin
    for (int lane = 0; lane < DispatchWidth; lane++)
    begin
      // Issue queue side.
      issueqGroup_o[lane].opcode       = renamedGroup_i[lane].opcode;
      issueqGroup_o[lane].immediate    = renamedGroup_i[lane].immediate;
      issueqGroup_o[lane].phySrc1      = renamedGroup_i[lane].phySrc1;
      issueqGroup_o[lane].phySrc2      = renamedGroup_i[lane].phySrc2;
      issueqGroup_o[lane].phyDest      = renamedGroup_i[lane].phyDest;
      issueqGroup_o[lane].checkpointId = renamedGroup_i[lane].checkpointId;
      issueqGroup_o[lane].branchMask   = updatedMask_i[lane];
      issueqGroup_o[lane].isLoad       = renamedGroup_i[lane].isLoad;
      issueqGroup_o[lane].isStore      = renamedGroup_i[lane].isStore;

      // Active list keeps what commit and recovery need.
      alGroup_o[lane].pc       = renamedGroup_i[lane].pc;
      alGroup_o[lane].logDest  = renamedGroup_i[lane].logDest;
      alGroup_o[lane].phyDest  = renamedGroup_i[lane].phyDest;
      alGroup_o[lane].isLoad   = renamedGroup_i[lane].isLoad;
      alGroup_o[lane].isStore  = renamedGroup_i[lane].isStore;
      alGroup_o[lane].isBranch = renamedGroup_i[lane].isBranch;

      // LSQ entry is allocated for every lane, flags tell it apart.
      lsqGroup_o[lane].branchMask = updatedMask_i[lane];
      lsqGroup_o[lane].isStore    = renamedGroup_i[lane].isStore;
      lsqGroup_o[lane].isLoad     = renamedGroup_i[lane].isLoad;
    end
  end

endmodule

`default_nettype wire

// File: logic/dispatchStageReg.sv
`timescale 1ns/1ps
`default_nettype none

module dispatchStageReg #(
  parameter type PayloadT = logic
)
(
  input  logic    clk,
  input  logic    arstN_i,
  input  logic    load_i,
  input  logic    flush_i,
  input  PayloadT data_i,
  output PayloadT data_o,
  output logic    valid_o
);

  PayloadT dataQ;
  logic    validQ;

  // Valid lasts one cycle per load.
  always_ff @(posedge clk or negedge arstN_i)
  begin
    if (!arstN_i)
    begin
      validQ <= 1'b0;
    end
    else
    begin
      validQ <= load_i & ~flush_i;
    end
  end

  always_ff @(posedge clk)
  begin
    if (load_i)
    begin
      dataQ <= data_i;
    end
  end

  assign data_o  = dataQ;
  assign valid_o = validQ;

  // The ready logic upstream already blocks dispatch during recovery.
  assert property (@(posedge clk) disable iff (!arstN_i) !(load_i && flush_i))
    else $error("dispatch load during recovery flush");

endmodule

`default_nettype wire

// File: logic/dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module dispatch
  import dispatchCfgPkg::*;
  import dispatchPacketPkg::*;
#(
  parameter int LsqSize        = 16,
  parameter int IssueQSize     = 32,
  parameter int ActiveListSize = 64
)
(
  input  logic         clk,
  input  logic         arstN_i,
  input  logic         renameReady_i,
  input  renamedGroupT renamedGroup_i,
  input  logic         flagRecoverEX_i,
  input  logic         ctrlVerified_i,
  input  checkpointIdT ctrlVerifiedId_i,
  input  lsqCntT       loadQueueCnt_i,
  input  lsqCntT       storeQueueCnt_i,
  input  issueqCntT    issueQueueCnt_i,
  input  alCntT        activeListCnt_i,
  output logic         backEndReady_o,
  output logic         stallFrontEnd_o,
  output maskGroupT    updatedBranchMask_o,
  output issueqGroupT  issueqGroup_o,
  output alGroupT      alGroup_o,
  output lsqGroupT     lsqGroup_o,
  output logic         dispatchValid_o
);

  logic        spaceStall;
  issueqGroupT issueqGroup;
  alGroupT     alGroup;
  lsqGroupT    lsqGroup;

  dispatchCapacityCheck #(
    .LsqSize        (LsqSize),
    .IssueQSize     (IssueQSize),
    .ActiveListSize (ActiveListSize)
  ) u_capacityCheck (
    .renamedGroup_i  (renamedGroup_i),
    .loadQueueCnt_i  (loadQueueCnt_i),
    .storeQueueCnt_i (storeQueueCnt_i),
    .issueQueueCnt_i (issueQueueCnt_i),
    .activeListCnt_i (activeListCnt_i),
    .spaceStall_o    (spaceStall)
  );

  // Masks also go back to the rename pipeline register.
  branchMaskUpdate u_branchMaskUpdate (
    .renamedGroup_i   (renamedGroup_i),
    .ctrlVerified_i   (ctrlVerified_i),
    .ctrlVerifiedId_i (ctrlVerifiedId_i),
    .updatedMask_o    (updatedBranchMask_o)
  );

  backEndPacketSplit u_packetSplit (
    .renamedGroup_i (renamedGroup_i),
    .updatedMask_i  (updatedBranchMask_o),
    .issueqGroup_o  (issueqGroup),
    .alGroup_o      (alGroup),
    .lsqGroup_o     (lsqGroup)
  );

  // Group moves on only when it fits and no squash is under way.
  assign backEndReady_o  = renameReady_i & ~spaceStall & ~flagRecoverEX_i;
  assign stallFrontEnd_o = spaceStall;

  dispatchStageReg #(
    .PayloadT (issueqGroupT)
  ) u_issueqReg (
    .clk     (clk),
    .arstN_i (arstN_i),
    .load_i  (backEndReady_o),
    .flush_i (flagRecoverEX_i),
    .data_i  (issueqGroup),
    .data_o  (issueqGroup_o),
    .valid_o (dispatchValid_o)
  );

  // Same load and flush, so one valid covers all three groups.
  dispatchStageReg #(
    .PayloadT (alGroupT)
  ) u_alReg (
    .clk     (clk),
    .arstN_i (arstN_i),
    .load_i  (backEndReady_o),
    .flush_i (flagRecoverEX_i),
    .data_i  (alGroup),
    .data_o  (alGroup_o),
    .valid_o ()
  );

  dispatchStageReg #(
    .PayloadT (lsqGroupT)
  ) u_lsqReg (
    .clk     (clk),
    .arstN_i (arstN_i),
    .load_i  (backEndReady_o),
    .flush_i (flagRecoverEX_i),
    .data_i  (lsqGroup),
    .data_o  (lsqGroup_o),
    .valid_o ()
  );

  // Rename only offers fully formed groups.
  assert property (@(posedge clk) disable iff (!arstN_i)
    renameReady_i |-> !$isunknown(renamedGroup_i))
    else $error("renamed group offered with unknown bits");

endmodule

`default_nettype wire

// File: testbench/dispatchChecker.sv
`timescale 1ns/1ps
`default_nettype none

module dispatchChecker
  import dispatchCfgPkg::*;
  import dispatchPacketPkg::*;
#(
  parameter int LsqSize        = 16,
  parameter int IssueQSize     = 32,
  parameter int ActiveListSize = 64
)
(
  input  logic         clk,
  input  logic         arstN_i,
  input  logic         renameReady_i,
  input  renamedGroupT renamedGroup_i,
  input  logic         flagRecoverEX_i,
  input  logic         ctrlVerified_i,
  input  checkpointIdT ctrlVerifiedId_i,
  input  lsqCntT       loadQueueCnt_i,
  input  lsqCntT       storeQueueCnt_i,
  input  issueqCntT    issueQueueCnt_i,
  input  alCntT        activeListCnt_i,
  input  logic         backEndReady_i,
  input  logic         stallFrontEnd_i,
  input  maskGroupT    updatedBranchMask_i,
  input  issueqGroupT  issueqGroup_i,
  input  alGroupT      alGroup_i,
  input  lsqGroupT     lsqGroup_i,
  input  logic         dispatchValid_i,
  output int           errorCnt_o,
  output int           pendingCnt_o
);

  // The three groups as they leave the stage registers.
  typedef struct packed {
    issueqGroupT iq;
    alGroupT     al;
    lsqGroupT    lsq;
  } latchedT;

  typedef struct packed {
    logic      ready;
    logic      stall;
    maskGroupT mask;
    latchedT   out;
  } expectT;

  expectT  expNow;
  latchedT expHead;
  latchedT expQ[$];

  // Expected levels, masks and entries for the group on the inputs.
  function automatic expectT reference(input renamedGroupT grp);
    expectT exp;
    int     loads;
    int     stores;
    loads  = 0;
    stores = 0;
    for (int lane = 0; lane < DispatchWidth; lane++)
    begin
      loads  += int'(grp[lane].isLoad);
      stores += int'(grp[lane].isStore);
      exp.mask[lane] = grp[lane].branchMask;
      if (ctrlVerified_i)
      begin
        exp.mask[lane][ctrlVerifiedId_i] = 1'b0;
      end
      exp.out.iq[lane] = '{opcode: grp[lane].opcode, immediate: grp[lane].immediate,
        phySrc1: grp[lane].phySrc1, phySrc2: grp[lane].phySrc2, phyDest: grp[lane].phyDest,
        checkpointId: grp[lane].checkpointId, branchMask: exp.mask[lane],
        isLoad: grp[lane].isLoad, isStore: grp[lane].isStore};
      exp.out.al[lane] = '{pc: grp[lane].pc, logDest: grp[lane].logDest,
        phyDest: grp[lane].phyDest, isLoad: grp[lane].isLoad,
        isStore: grp[lane].isStore, isBranch: grp[lane].isBranch};
      exp.out.lsq[lane] = '{branchMask: exp.mask[lane], isStore: grp[lane].isStore,
        isLoad: grp[lane].isLoad};
    end
    // Any one structure without room is enough to stall.
    exp.stall = (int'(loadQueueCnt_i) + loads > LsqSize)
      || (int'(storeQueueCnt_i) + stores > LsqSize)
      || (int'(issueQueueCnt_i) + DispatchWidth > IssueQSize)
      || (int'(activeListCnt_i) + DispatchWidth > ActiveListSize);
    exp.ready = renameReady_i && !exp.stall && !flagRecoverEX_i;
    return exp;
  endfunction

  task automatic logMismatch(input string msg);
    errorCnt_o++;
    $display("FAILED at %0t: %s", $time, msg);
  endtask

  // Inputs change on the rising edge, so everything is compared mid-cycle.
  always @(negedge clk)
  begin
    if (expQ.size() != 0)
    begin
      expHead = expQ.pop_front();
      if (dispatchValid_i !== 1'b1)
      begin
        logMismatch("dispatchValid_o low one cycle after a dispatching edge");
      end
      else if ({issueqGroup_i, alGroup_i, lsqGroup_i} !== expHead)
      begin
        logMismatch("latched entry groups differ from the expected groups");
      end
    end
    else if (dispatchValid_i !== 1'b0)
    begin
      logMismatch("dispatchValid_o high without a dispatching edge");
    end
    expNow = reference(renamedGroup_i);
    if (stallFrontEnd_i !== expNow.stall)
    begin
      logMismatch($sformatf("stallFrontEnd_o %b, expected %b", stallFrontEnd_i, expNow.stall));
    end
    if (backEndReady_i !== expNow.ready)
    begin
      logMismatch($sformatf("backEndReady_o %b, expected %b", backEndReady_i, expNow.ready));
    end
    if (updatedBranchMask_i !== expNow.mask)
    begin
      logMismatch($sformatf("updatedBranchMask_o %h, expected %h",
        updatedBranchMask_i, expNow.mask));
    end
    // This group is latched on the coming rising edge.
    if (arstN_i && expNow.ready)
    begin
      expQ.push_back(expNow.out);
    end
    pendingCnt_o = expQ.size();
  end

endmodule

`default_nettype wire

// File: testbench/dispatchTb.sv
`timescale 1ns/1ps
`default_nettype none

module dispatchTb
  import dispatchCfgPkg::*;
  import dispatchPacketPkg::*;
();

  localparam int LsqSize        = 16;
  localparam int IssueQSize     = 32;
  localparam int ActiveListSize = 64;
  localparam int WaitLimit      = 8;

  // Occupancy levels reported by the back end.
  typedef struct packed {
    lsqCntT    ld;
    lsqCntT    st;
    issueqCntT iq;
    alCntT     al;
  } occT;

  logic         clk;
  logic         arstN;
  logic         renameReady;
  logic         flagRecoverEX;
  logic         ctrlVerified;
  checkpointIdT ctrlVerifiedId;
  renamedGroupT renamedGroup;
  occT          occupancy;
  logic         backEndReady;
  logic         stallFrontEnd;
  logic         dispatchValid;
  maskGroupT    updatedBranchMask;
  issueqGroupT  issueqGroup;
  alGroupT      alGroup;
  lsqGroupT     lsqGroup;
  int           errorCnt;
  int           pendingCnt;
  int           timeoutCnt;

  initial
  begin
    clk = 1'b0;
  end

  always #20 clk = ~clk;

  dispatch #(
    .LsqSize        (LsqSize),
    .IssueQSize     (IssueQSize),
    .ActiveListSize (ActiveListSize)
  ) u_dispatch (
    .clk                 (clk),
    .arstN_i             (arstN),
    .renameReady_i       (renameReady),
    .renamedGroup_i      (renamedGroup),
    .flagRecoverEX_i     (flagRecoverEX),
    .ctrlVerified_i      (ctrlVerified),
    .ctrlVerifiedId_i    (ctrlVerifiedId),
    .loadQueueCnt_i      (occupancy.ld),
    .storeQueueCnt_i     (occupancy.st),
    .issueQueueCnt_i     (occupancy.iq),
    .activeListCnt_i     (occupancy.al),
    .backEndReady_o      (backEndReady),
    .stallFrontEnd_o     (stallFrontEnd),
    .updatedBranchMask_o (updatedBranchMask),
    .issueqGroup_o       (issueqGroup),
    .alGroup_o           (alGroup),
    .lsqGroup_o          (lsqGroup),
    .dispatchValid_o     (dispatchValid)
  );

  dispatchChecker #(
    .LsqSize        (LsqSize),
    .IssueQSize     (IssueQSize),
    .ActiveListSize (ActiveListSize)
  ) u_checker (
    .clk                 (clk),
    .arstN_i             (arstN),
    .renameReady_i       (renameReady),
    .renamedGroup_i      (renamedGroup),
    .flagRecoverEX_i     (flagRecoverEX),
    .ctrlVerified_i      (ctrlVerified),
    .ctrlVerifiedId_i    (ctrlVerifiedId),
    .loadQueueCnt_i      (occupancy.ld),
    .storeQueueCnt_i     (occupancy.st),
    .issueQueueCnt_i     (occupancy.iq),
    .activeListCnt_i     (occupancy.al),
    .backEndReady_i      (backEndReady),
    .stallFrontEnd_i     (stallFrontEnd),
    .updatedBranchMask_i (updatedBranchMask),
    .issueqGroup_i       (issueqGroup),
    .alGroup_i           (alGroup),
    .lsqGroup_i          (lsqGroup),
    .dispatchValid_i     (dispatchValid),
    .errorCnt_o          (errorCnt),
    .pendingCnt_o        (pendingCnt)
  );

  function automatic occT makeOcc(input int ld, input int st, input int iq, input int al);
    occT occ;
    occ.ld = lsqCntT'(ld);
    occ.st = lsqCntT'(st);
    occ.iq = issueqCntT'(iq);
    occ.al = alCntT'(al);
    return occ;
  endfunction

  function automatic occT randomOcc();
    return makeOcc($urandom_range(0, LsqSize), $urandom_range(0, LsqSize),
      $urandom_range(0, IssueQSize), $urandom_range(0, ActiveListSize));
  endfunction

  // No lane is both a load and a store.
  function automatic renamedGroupT randomGroup();
    logic [$bits(renamedGroupT)-1:0] raw;
    renamedGroupT                    grp;
    for (int b = 0; b < $bits(raw); b++)
    begin
      raw[b] = 1'($urandom());
    end
    grp = renamedGroupT'(raw);
    for (int lane = 0; lane < DispatchWidth; lane++)
    begin
      if (grp[lane].isLoad)
      begin
        grp[lane].isStore = 1'b0;
      end
    end
    return grp;
  endfunction

  // Two loads and one store.
  function automatic renamedGroupT mixGroup();
    renamedGroupT grp;
    grp = randomGroup();
    for (int lane = 0; lane < DispatchWidth; lane++)
    begin
      grp[lane].isLoad  = (lane < 2);
      grp[lane].isStore = (lane == 2);
    end
    return grp;
  endfunction

  task automatic drive(input renamedGroupT grp, input occT occ, input logic rdy,
                       input logic recover);
    @(posedge clk);
    renamedGroup   <= grp;
    occupancy      <= occ;
    renameReady    <= rdy;
    flagRecoverEX  <= recover;
    ctrlVerified   <= ($urandom_range(0, 1) == 1);
    ctrlVerifiedId <= checkpointIdT'($urandom_range(0, Checkpoints - 1));
  endtask

  task automatic awaitValid();
    int waited;
    waited = 0;
    @(negedge clk);
    while (!dispatchValid && waited < WaitLimit)
    begin
      @(negedge clk);
      waited++;
    end
    if (!dispatchValid)
    begin
      timeoutCnt++;
      $display("Timeout: no dispatched group appeared within %0d cycles", WaitLimit);
    end
  endtask

  task automatic drainWait();
    int waited;
    waited = 0;
    @(posedge clk);
    while (pendingCnt != 0 && waited < WaitLimit)
    begin
      @(posedge clk);
      waited++;
    end
    if (pendingCnt != 0)
    begin
      timeoutCnt++;
      $display("Timeout: %0d dispatched groups were never seen at the outputs", pendingCnt);
    end
  endtask

  initial
  begin
    void'($urandom(32'h01de_bd9e));
    timeoutCnt = 0;
    arstN          <= 1'b0;
    renameReady    <= 1'b0;
    flagRecoverEX  <= 1'b0;
    ctrlVerified   <= 1'b0;
    ctrlVerifiedId <= '0;
    renamedGroup   <= '0;
    occupancy      <= '0;
    repeat (5) @(posedge clk);
    arstN <= 1'b1;

    // One group with plenty of room.
    drive(mixGroup(), makeOcc(0, 0, 0, 0), 1'b1, 1'b0);
    drive(mixGroup(), makeOcc(0, 0, 0, 0), 1'b0, 1'b0);
    awaitValid();

    // Each structure one below, at and one above its limit.
    for (int d = -1; d <= 1; d++)
    begin
      drive(mixGroup(), makeOcc(LsqSize - 2 + d, 0, 0, 0), 1'b1, 1'b0);
      drive(mixGroup(), makeOcc(0, LsqSize - 1 + d, 0, 0), 1'b1, 1'b0);
      drive(mixGroup(), makeOcc(0, 0, IssueQSize - DispatchWidth + d, 0), 1'b1, 1'b0);
      drive(mixGroup(), makeOcc(0, 0, 0, ActiveListSize - DispatchWidth + d), 1'b1, 1'b0);
    end

    // Squash under way.
    repeat (3) drive(randomGroup(), makeOcc(0, 0, 0, 0), 1'b1, 1'b1);

    repeat (300) drive(randomGroup(), randomOcc(), ($urandom_range(0, 7) != 0),
      ($urandom_range(0, 15) == 0));
    drive(randomGroup(), makeOcc(0, 0, 0, 0), 1'b0, 1'b0);
    drainWait();

    $display("Errors: %0d mismatches, %0d timeouts", errorCnt, timeoutCnt);
    if (errorCnt == 0 && timeoutCnt == 0)
    begin
      $display("TEST PASSED");
    end
    else
    begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
logic/dispatchCfgPkg.sv
logic/dispatchPacketPkg.sv
logic/dispatchCapacityCheck.sv
logic/branchMaskUpdate.sv
logic/backEndPacketSplit.sv
logic/dispatchStageReg.sv
logic/dispatch.sv
testbench/dispatchChecker.sv
testbench/dispatchTb.sv

// File: Bender.yml
package:
  name: dispatch

sources:
  - logic/dispatchCfgPkg.sv
  - logic/dispatchPacketPkg.sv
  - logic/dispatchCapacityCheck.sv
  - logic/branchMaskUpdate.sv
  - logic/backEndPacketSplit.sv
  - logic/dispatchStageReg.sv
  - logic/dispatch.sv
  - target: test
    files:
      - testbench/dispatchChecker.sv
      - testbench/dispatchTb.sv
